// ==== vlog.f ====
hw/bounce_pkg.sv
hw/video_if.sv
hw/display_timings.sv
hw/square_mover.sv
hw/square_painter.sv
hw/bounce_top.sv
verif/tb_bounce.sv

// ==== Makefile ====
# Verilator flow for the bouncing squares demo

VERILATOR ?= verilator
TOP       ?= tb_bounce
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then decide on the log contents
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "sim: pass"; \
	else \
		echo "sim: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG) *.log

// ==== verif/tb_bounce.sv ====
// bouncing squares testbench
// follows the raster on the VGA outputs and checks syncs, blanking and square motion

`timescale 1ns/1ps
`default_nettype none

module tb_bounce import bounce_pkg::*; ();

    localparam int FRAMES      = 6;
    localparam int FRAME_CYC   = 800 * 525;
    localparam int WATCHDOG_NS = FRAMES * FRAME_CYC * 8 * 3 / 2;  // 1.5x six frames

    logic   clk_pix = 1'b0;
    logic   reset;
    logic   vga_hsync;
    logic   vga_vsync;
    color_t vga_r;
    color_t vga_g;
    color_t vga_b;

    string cur_test;
    int    test_errs;
    int    pass_cnt   = 0;
    int    fail_cnt   = 0;
    int    cyc        = 0;   // output samples since reset
    int    last_hfall = -1;
    int    last_vfall = -1;
    int    vfall_cnt  = 0;
    logic  prev_h     = 1'b1;
    logic  prev_v     = 1'b1;

    // square set-up of the top level defaults
    int    sq_size   [3] = '{100, 150, 200};
    int    sq_speed  [3] = '{3, 2, 2};
    int    sq_init_x [3] = '{530, 10, 300};
    int    sq_init_y [3] = '{20, 200, 274};
    string ch_name   [3] = '{"red", "green", "blue"};

    int ref_x     [FRAMES][3];  // predicted origins
    int ref_y     [FRAMES][3];
    int box_x0    [FRAMES][3];  // observed lit area
    int box_y0    [FRAMES][3];
    int box_x1    [FRAMES][3];
    int box_y1    [FRAMES][3];
    int lit_cnt   [FRAMES][3];
    int odd_lvl   [FRAMES][3];  // lit but not full intensity
    int blank_lit [FRAMES];

    bounce_top u_bounce_top (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    always #4 clk_pix = ~clk_pix;  // 8 ns pixel clock

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic color_t channel(input int ch);
        case (ch)
            0:       return vga_r;
            1:       return vga_g;
            default: return vga_b;
        endcase
    endfunction

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: pass", cur_test);
        end else begin
            fail_cnt++;
            $display("test %s: fail, %0d mismatches", cur_test, test_errs);
        end
    endtask

    task automatic report_mismatch(input string what, input int exp, input int act);
        $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        test_errs++;
    endtask

    // one axis of the bounce rule, back means up or left
    task automatic step_axis(inout int pos, inout bit back, input int res,
                             input int size, input int speed);
        if (pos >= res - (size + speed)) begin
            back = 1'b1;
            pos  = pos - speed;
        end else if (pos < speed) begin
            back = 1'b0;
            pos  = pos + speed;
        end else begin
            pos = back ? pos - speed : pos + speed;
        end
    endtask

    task automatic compute_reference();
        int f;
        int q;
        int px;
        int py;
        bit bx;
        bit by;
        for (q = 0; q < 3; q++) begin
            px = sq_init_x[q];
            py = sq_init_y[q];
            bx = 1'b0;  // starts right and down
            by = 1'b0;
            for (f = 0; f < FRAMES; f++) begin
                ref_x[f][q] = px;
                ref_y[f][q] = py;
                step_axis(px, bx, 640, sq_size[q], sq_speed[q]);
                step_axis(py, by, 480, sq_size[q], sq_speed[q]);
            end
        end
    endtask

    task automatic check_idle(input string where);
        int ch;
        if (vga_hsync !== 1'b1) report_mismatch({where, " hsync"}, 1, int'(vga_hsync));
        if (vga_vsync !== 1'b1) report_mismatch({where, " vsync"}, 1, int'(vga_vsync));
        for (ch = 0; ch < 3; ch++) begin
            if (channel(ch) !== 4'd0) begin
                report_mismatch({where, " ", ch_name[ch]}, 0, int'(channel(ch)));
            end
        end
    endtask

    task automatic check_sync(input int x, input int y);
        logic exp_h;
        logic exp_v;
        exp_h = !(x >= 656 && x < 752);
        exp_v = !(y >= 490 && y < 492);
        if (vga_hsync !== exp_h) begin
            report_mismatch($sformatf("hsync at (%0d,%0d)", x, y), int'(exp_h), int'(vga_hsync));
        end
        if (vga_vsync !== exp_v) begin
            report_mismatch($sformatf("vsync at (%0d,%0d)", x, y), int'(exp_v), int'(vga_vsync));
        end
        if (prev_h && !vga_hsync) begin  // falling edge, one per line
            if (last_hfall >= 0 && cyc - last_hfall != 800) begin
                report_mismatch("line length", 800, cyc - last_hfall);
            end
            last_hfall = cyc;
        end
        if (prev_v && !vga_vsync) begin
            if (last_vfall >= 0 && cyc - last_vfall != FRAME_CYC) begin
                report_mismatch("frame length", FRAME_CYC, cyc - last_vfall);
            end
            last_vfall = cyc;
            vfall_cnt++;
        end
        prev_h = vga_hsync;
        prev_v = vga_vsync;
    endtask

    // walks one frame of output samples, 1 cycle behind the internal raster
    task automatic capture_frame(input int f, input bit chk_sync);
        int     x;
        int     y;
        int     ch;
        color_t lvl;
        blank_lit[f] = 0;
        for (ch = 0; ch < 3; ch++) begin
            box_x0[f][ch]  = 1 << 20;
            box_y0[f][ch]  = 1 << 20;
            box_x1[f][ch]  = -1;
            box_y1[f][ch]  = -1;
            lit_cnt[f][ch] = 0;
            odd_lvl[f][ch] = 0;
        end
        for (y = 0; y < 525; y++) begin
            for (x = 0; x < 800; x++) begin
                @(posedge clk_pix);
                #1;
                cyc++;
                if (chk_sync) check_sync(x, y);
                for (ch = 0; ch < 3; ch++) begin
                    lvl = channel(ch);
                    if (lvl != 4'd0 && (x >= 640 || y >= 480)) begin
                        blank_lit[f]++;
                    end else if (lvl != 4'd0) begin
                        lit_cnt[f][ch]++;
                        if (lvl != 4'd15) odd_lvl[f][ch]++;
                        if (x < box_x0[f][ch]) box_x0[f][ch] = x;
                        if (y < box_y0[f][ch]) box_y0[f][ch] = y;
                        if (x > box_x1[f][ch]) box_x1[f][ch] = x;
                        if (y > box_y1[f][ch]) box_y1[f][ch] = y;
                    end
                end
            end
        end
    endtask

    task automatic check_squares(input int f);
        int    ch;
        int    sz;
        string tag;
        for (ch = 0; ch < 3; ch++) begin
            sz  = sq_size[ch];
            tag = $sformatf("frame %0d %s", f, ch_name[ch]);
            if (lit_cnt[f][ch] != sz * sz) begin
                report_mismatch({tag, " lit pixels"}, sz * sz, lit_cnt[f][ch]);
            end
            if (box_x0[f][ch] != ref_x[f][ch]) begin
                report_mismatch({tag, " origin x"}, ref_x[f][ch], box_x0[f][ch]);
            end
            if (box_y0[f][ch] != ref_y[f][ch]) begin
                report_mismatch({tag, " origin y"}, ref_y[f][ch], box_y0[f][ch]);
            end
            if (box_x1[f][ch] - box_x0[f][ch] + 1 != sz) begin
                report_mismatch({tag, " width"}, sz, box_x1[f][ch] - box_x0[f][ch] + 1);
            end
            if (box_y1[f][ch] - box_y0[f][ch] + 1 != sz) begin
                report_mismatch({tag, " height"}, sz, box_y1[f][ch] - box_y0[f][ch] + 1);
            end
            if (odd_lvl[f][ch] != 0) begin
                report_mismatch({tag, " pixels below full level"}, 0, odd_lvl[f][ch]);
            end
        end
    endtask

    task automatic reset_state();
        int i;
        start_test("reset_state");
        reset = 1'b1;
        for (i = 0; i < 10; i++) begin
            @(posedge clk_pix);
            #1;
            check_idle("in reset");
        end
        reset = 1'b0;  // released 1 ns after the 10th edge
        #2;
        check_idle("first cycle after reset");
        finish_test();
    endtask

    task automatic sync_timing();
        start_test("sync_timing");
        capture_frame(0, 1'b1);
        capture_frame(1, 1'b1);
        if (vfall_cnt != 2) report_mismatch("vsync pulses", 2, vfall_cnt);
        finish_test();
    endtask

    task automatic first_frame_squares();
        start_test("first_frame_squares");
        check_squares(0);
        finish_test();
    endtask

    task automatic bounce_motion();
        int f;
        start_test("bounce_motion");
        for (f = 2; f < FRAMES; f++) begin
            capture_frame(f, 1'b0);
        end
        for (f = 1; f < FRAMES; f++) begin
            check_squares(f);
        end
        finish_test();
    endtask

    task automatic blanking_black();
        int f;
        start_test("blanking_black");
        for (f = 0; f < FRAMES; f++) begin
            if (blank_lit[f] != 0) begin
                report_mismatch($sformatf("frame %0d lit blanking samples", f), 0, blank_lit[f]);
            end
        end
        finish_test();
    endtask

    initial begin
        compute_reference();
        reset_state();
        sync_timing();
        first_frame_squares();
        bounce_motion();
        blanking_black();
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/bounce_top.sv ====
// bouncing squares VGA demo, 640x480
// timing generator, three square movers and the colour painter

`timescale 1ns/1ps
`default_nettype none

module bounce_top import bounce_pkg::*; #(
    parameter coord_t Q1_SIZE   = 100,
    parameter speed_t Q1_SPEED  = 3,
    parameter coord_t Q1_INIT_X = 530,  // right edge bounce early
    parameter coord_t Q1_INIT_Y = 20,
    parameter coord_t Q2_SIZE   = 150,
    parameter speed_t Q2_SPEED  = 2,
    parameter coord_t Q2_INIT_X = 10,
    parameter coord_t Q2_INIT_Y = 200,
    parameter coord_t Q3_SIZE   = 200,
    parameter speed_t Q3_SPEED  = 2,
    parameter coord_t Q3_INIT_X = 300,
    parameter coord_t Q3_INIT_Y = 274   // bottom edge bounce early
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    output logic      vga_hsync,
    output logic      vga_vsync,
    output color_t    vga_r,
    output color_t    vga_g,
    output color_t    vga_b
);

    video_if vid ();

    coord_t q1_x, q1_y;
    coord_t q2_x, q2_y;
    coord_t q3_x, q3_y;

    display_timings u_timings (
        .clk_pix (clk_pix),
        .reset   (reset),
        .vid     (vid.source)
    );

    square_mover #(
        .SIZE(Q1_SIZE), .SPEED(Q1_SPEED), .INIT_X(Q1_INIT_X), .INIT_Y(Q1_INIT_Y)
    ) u_mover_q1 (
        .clk_pix (clk_pix),
        .reset   (reset),
        .vid     (vid.sink),
        .pos_x   (q1_x),
        .pos_y   (q1_y)
    );

    square_mover #(
        .SIZE(Q2_SIZE), .SPEED(Q2_SPEED), .INIT_X(Q2_INIT_X), .INIT_Y(Q2_INIT_Y)
    ) u_mover_q2 (
        .clk_pix (clk_pix),
        .reset   (reset),
        .vid     (vid.sink),
        .pos_x   (q2_x),
        .pos_y   (q2_y)
    );

    square_mover #(
        .SIZE(Q3_SIZE), .SPEED(Q3_SPEED), .INIT_X(Q3_INIT_X), .INIT_Y(Q3_INIT_Y)
    ) u_mover_q3 (
        .clk_pix (clk_pix),
        .reset   (reset),
        .vid     (vid.sink),
        .pos_x   (q3_x),
        .pos_y   (q3_y)
    );

    square_painter #(
        .Q1_SIZE(Q1_SIZE), .Q2_SIZE(Q2_SIZE), .Q3_SIZE(Q3_SIZE)
    ) u_painter (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .vid       (vid.sink),
        .q1_x      (q1_x),
        .q1_y      (q1_y),
        .q2_x      (q2_x),
        .q2_y      (q2_y),
        .q3_x      (q3_x),
        .q3_y      (q3_y),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

// ==== hw/square_painter.sv ====
// per-pixel hit test for three squares
// one colour channel per square, registered together with the syncs

`timescale 1ns/1ps
`default_nettype none

module square_painter import bounce_pkg::*; #(
    parameter coord_t Q1_SIZE = 100,
    parameter coord_t Q2_SIZE = 150,
    parameter coord_t Q3_SIZE = 200
) (
    input  wire logic   clk_pix,
    input  wire logic   reset,
    video_if.sink       vid,
    input  wire coord_t q1_x,
    input  wire coord_t q1_y,
    input  wire coord_t q2_x,
    input  wire coord_t q2_y,
    input  wire coord_t q3_x,
    input  wire coord_t q3_y,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output color_t      vga_r,
    output color_t      vga_g,
    output color_t      vga_b
);

    localparam color_t FULL = '1;  // intensity 15

    logic q1_hit;
    logic q2_hit;
    logic q3_hit;

    // square covers origin up to origin + size, exclusive
    function automatic logic in_square(
        input coord_t x,
        input coord_t y,
        input coord_t qx,
        input coord_t qy,
        input coord_t size
    );
        return (x >= qx) && (int'(x) < int'(qx) + int'(size))
            && (y >= qy) && (int'(y) < int'(qy) + int'(size));
    endfunction

    always_comb begin
        q1_hit = in_square(vid.sx, vid.sy, q1_x, q1_y, Q1_SIZE);
        q2_hit = in_square(vid.sx, vid.sy, q2_x, q2_y, Q2_SIZE);
        q3_hit = in_square(vid.sx, vid.sy, q3_x, q3_y, Q3_SIZE);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;  // inactive
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= vid.hsync;  // same stage as colour
            vga_vsync <= vid.vsync;
            vga_r     <= (vid.de && q1_hit) ? FULL : color_t'(0);
            vga_g     <= (vid.de && q2_hit) ? FULL : color_t'(0);
            vga_b     <= (vid.de && q3_hit) ? FULL : color_t'(0);
        end
    end

endmodule

`default_nettype wire

// ==== hw/square_mover.sv ====
// position of one bouncing square
// steps once per frame and reverses at the screen edges

`timescale 1ns/1ps
`default_nettype none

module square_mover import bounce_pkg::*; #(
    parameter coord_t SIZE   = 100,  // side length in pixels
    parameter speed_t SPEED  = 3,    // pixels per frame
    parameter coord_t INIT_X = 0,
    parameter coord_t INIT_Y = 0
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    video_if.sink     vid,
    output coord_t    pos_x,
    output coord_t    pos_y
);

    logic   dir_x;   // 1 moves left
    logic   dir_y;   // 1 moves up
    coord_t next_x;
    coord_t next_y;
    logic   next_dir_x;
    logic   next_dir_y;

    // bounce rule for one axis, res is the visible extent of that axis
    function automatic void bounce(
        input  coord_t pos,
        input  logic   dir,
        input  int     res,
        output coord_t pos_n,
        output logic   dir_n
    );
        int far_edge;
        far_edge = res - (int'(SIZE) + int'(SPEED));
        if (int'(pos) >= far_edge) begin
            dir_n = 1'b1;                      // turn back toward origin
            pos_n = pos - coord_t'(SPEED);
        end else if (int'(pos) < int'(SPEED)) begin
            dir_n = 1'b0;                      // turn away from origin
            pos_n = pos + coord_t'(SPEED);
        end else begin
            dir_n = dir;
            pos_n = dir ? pos - coord_t'(SPEED) : pos + coord_t'(SPEED);
        end
    endfunction

    always_comb begin
        bounce(pos_x, dir_x, H_RES, next_x, next_dir_x);
        bounce(pos_y, dir_y, V_RES, next_y, next_dir_y);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            pos_x <= INIT_X;
            pos_y <= INIT_Y;
            dir_x <= 1'b0;  // start right
            dir_y <= 1'b0;  // start down
        end else if (vid.frame_start) begin
            pos_x <= next_x;
            pos_y <= next_y;
            dir_x <= next_dir_x;
            dir_y <= next_dir_y;
        end
    end

    // square stays fully on screen across every update
    fits_h: assert property (
        @(posedge clk_pix) disable iff (reset)
        int'(pos_x) + int'(SIZE) <= H_RES
    );

    fits_v: assert property (
        @(posedge clk_pix) disable iff (reset)
        int'(pos_y) + int'(SIZE) <= V_RES
    );

endmodule

`default_nettype wire

// ==== hw/display_timings.sv ====
// 640x480 display timing generator
// free-running raster counters with data enable, syncs and a per-frame strobe

`timescale 1ns/1ps
`default_nettype none

module display_timings import bounce_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic reset,
    video_if.source   vid
);

    coord_t sx;
    coord_t sy;
    logic   line_end;
    logic   frame_end;

    always_comb begin
        line_end  = (sx == coord_t'(H_TOTAL - 1));
        frame_end = (sy == coord_t'(V_TOTAL - 1));
    end

    // pixel and line counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? coord_t'(0) : sy + 1'b1;  // next line or wrap
        end else begin
            sx <= sx + 1'b1;
        end
    end

    logic h_active;
    logic v_active;
    logic h_in_sync;
    logic v_in_sync;

    always_comb begin
        h_active  = (sx < coord_t'(H_RES));
        v_active  = (sy < coord_t'(V_RES));
        h_in_sync = (sx >= coord_t'(H_SYNC_START)) && (sx < coord_t'(H_SYNC_END));
        v_in_sync = (sy >= coord_t'(V_SYNC_START)) && (sy < coord_t'(V_SYNC_END));
    end

    assign vid.sx          = sx;
    assign vid.sy          = sy;
    assign vid.de          = h_active && v_active;
    assign vid.hsync       = !h_in_sync;  // active low
    assign vid.vsync       = !v_in_sync;  // active low

    // first pixel of vertical blanking, animation happens here
    assign vid.frame_start = (sy == coord_t'(V_RES)) && (sx == '0);

    // horizontal counter never reaches the wrap value
    sx_in_range: assert property (
        @(posedge clk_pix) disable iff (reset)
        vid.sx < coord_t'(H_TOTAL)
    );

    // movers rely on the strobe landing outside the visible area
    frame_start_blank: assert property (
        @(posedge clk_pix) disable iff (reset)
        vid.frame_start |-> !vid.de
    );

endmodule

`default_nettype wire

// ==== hw/video_if.sv ====
// raster bundle from the display timing generator to its consumers
// carries position, blanking, active-low syncs and the frame strobe

`timescale 1ns/1ps
`default_nettype none

interface video_if import bounce_pkg::*; ();

    coord_t sx;           // horizontal position, 0 to 799
    coord_t sy;           // vertical position, 0 to 524
    logic   de;           // visible area
    logic   hsync;        // active low
    logic   vsync;        // active low
    logic   frame_start;  // one cycle at sy 480, sx 0

    // timing generator side
    modport source (
        output sx, sy, de, hsync, vsync, frame_start
    );

    // movers and painter
    modport sink (
        input sx, sy, de, hsync, vsync, frame_start
    );

endinterface

`default_nettype wire

// ==== hw/bounce_pkg.sv ====
// bounce demo shared types and fixed 640x480 video timing constants
// all timing values are in pixels horizontally and lines vertically

`default_nettype none

package bounce_pkg;

    typedef logic [9:0] coord_t;   // screen coordinate
    typedef logic [3:0] color_t;   // one vga colour channel
    typedef logic [7:0] speed_t;   // pixels moved per frame

    // visible area
    parameter int H_RES = 640;
    parameter int V_RES = 480;

    // horizontal timing
    parameter int H_FP   = 16;     // front porch
    parameter int H_SYNC = 96;     // sync pulse width
    parameter int H_BP   = 48;     // back porch

    // vertical timing
    parameter int V_FP   = 10;
    parameter int V_SYNC = 2;
    parameter int V_BP   = 33;

    // counter wrap points
    parameter int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    parameter int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // sync windows
    parameter int H_SYNC_START = H_RES + H_FP;             // 656
    parameter int H_SYNC_END   = H_SYNC_START + H_SYNC;    // 752, exclusive
    parameter int V_SYNC_START = V_RES + V_FP;             // 490
    parameter int V_SYNC_END   = V_SYNC_START + V_SYNC;    // 492, exclusive

endpackage

`default_nettype wire
